//--- verilog/ucode_settings.svh
`ifndef UCODE_SETTINGS_SVH
`define UCODE_SETTINGS_SVH

// Opcode byte width
`define UCODE_OPCODE_W 8

// ROM address and flow index width
`define UCODE_FLOW_W 7

// Micro-op field widths
`define UCODE_OP_W 5
`define UCODE_OPERAND_W 5

// Opcode FIFO entries
`define UCODE_QUEUE_DEPTH 4

`endif

//--- verilog/isaPkg.sv
`default_nettype none
`include "ucode_settings.svh"

package isaPkg;

	typedef logic [`UCODE_OPCODE_W-1:0] opcode_t;

	//////////////////////////////
	// One byte and immediate loads
	localparam opcode_t opNop = 8'h00;
	localparam opcode_t opLdA = 8'h3E;
	localparam opcode_t opLdB = 8'h06;
	localparam opcode_t opLdC = 8'h0E;
	localparam opcode_t opLdD = 8'h16;
	localparam opcode_t opLdE = 8'h1E;
	localparam opcode_t opLdH = 8'h26;
	localparam opcode_t opLdL = 8'h2E;

	//////////////////////////////
	// 8-bit arithmetic
	localparam opcode_t opIncA = 8'h3C;
	localparam opcode_t opIncB = 8'h04;
	localparam opcode_t opIncC = 8'h0C;
	localparam opcode_t opIncD = 8'h14;
	localparam opcode_t opIncE = 8'h1C;
	localparam opcode_t opIncH = 8'h24;
	localparam opcode_t opIncL = 8'h2C;
	localparam opcode_t opDecA = 8'h3D;
	localparam opcode_t opDecB = 8'h05;
	localparam opcode_t opDecC = 8'h0D;
	localparam opcode_t opDecD = 8'h15;
	localparam opcode_t opDecE = 8'h1D;
	localparam opcode_t opDecH = 8'h25;
	localparam opcode_t opDecL = 8'h2D;
	localparam opcode_t opAddB = 8'h80;
	localparam opcode_t opAddC = 8'h81;
	localparam opcode_t opAddD = 8'h82;
	localparam opcode_t opAddE = 8'h83;
	localparam opcode_t opSubB = 8'h90;
	localparam opcode_t opSubC = 8'h91;
	localparam opcode_t opSubD = 8'h92;

	//////////////////////////////
	// Stack
	localparam opcode_t opPushBc = 8'hC5;
	localparam opcode_t opPushDe = 8'hD5;
	localparam opcode_t opPushHl = 8'hE5;
	localparam opcode_t opPushAf = 8'hF5;
	localparam opcode_t opPopBc = 8'hC1;
	localparam opcode_t opPopDe = 8'hD1;
	localparam opcode_t opPopHl = 8'hE1;
	localparam opcode_t opPopAf = 8'hF1;

	// CB prefix and the second bytes it knows
	localparam opcode_t opCbPrefix = 8'hCB;
	localparam opcode_t opCbBit7H = 8'h7C;
	localparam opcode_t opCbRlC = 8'h11;

endpackage

`default_nettype wire

//--- verilog/ucodePkg.sv
`default_nettype none
`include "ucode_settings.svh"

package ucodePkg;

	typedef logic [`UCODE_FLOW_W-1:0] flowIdx_t;

	typedef enum logic [`UCODE_OP_W-1:0] {
		opNop,
		opSma,       // memory address
		opSmw,       // memory write
		opSrm,       // register from memory
		opInc,
		opDec,
		opAdd,
		opSub,
		opShl,
		opBit,
		opSx16r,     // copy to x16
		opSrx16,     // copy from x16
		opZ801bop,
		opJcb
	} uopOp_e;

	typedef enum logic [`UCODE_OPERAND_W-1:0] {
		opdNull,
		opdA, opdB, opdC, opdD, opdE, opdF, opdH, opdL,
		opdSp, opdPc, opdHl, opdBc, opdDe, opdX16
	} uopOperand_e;

	typedef struct packed {
		logic incPc;
		logic flowEnd;
		logic updateFlags;
		uopOp_e op;
		uopOperand_e operand;
	} uop_t;

	//////////////////////////////
	// Flow entry points in the ROM
	localparam flowIdx_t flowDefault = 7'd0;
	localparam flowIdx_t flowNop = 7'd2;
	localparam flowIdx_t flowCbPrefix = 7'd3;
	localparam flowIdx_t flowCbBit7H = 7'd6;
	localparam flowIdx_t flowCbRlC = 7'd7;
	localparam flowIdx_t flowCbDefault = 7'd8;

	// Three words each, A B C D E H L
	localparam flowIdx_t flowLdA = 7'd9;
	localparam flowIdx_t flowLdB = 7'd12;
	localparam flowIdx_t flowLdC = 7'd15;
	localparam flowIdx_t flowLdD = 7'd18;
	localparam flowIdx_t flowLdE = 7'd21;
	localparam flowIdx_t flowLdH = 7'd24;
	localparam flowIdx_t flowLdL = 7'd27;

	// Two words each
	localparam flowIdx_t flowIncA = 7'd30;
	localparam flowIdx_t flowIncB = 7'd32;
	localparam flowIdx_t flowIncC = 7'd34;
	localparam flowIdx_t flowIncD = 7'd36;
	localparam flowIdx_t flowIncE = 7'd38;
	localparam flowIdx_t flowIncH = 7'd40;
	localparam flowIdx_t flowIncL = 7'd42;
	localparam flowIdx_t flowDecA = 7'd44;
	localparam flowIdx_t flowDecB = 7'd46;
	localparam flowIdx_t flowDecC = 7'd48;
	localparam flowIdx_t flowDecD = 7'd50;
	localparam flowIdx_t flowDecE = 7'd52;
	localparam flowIdx_t flowDecH = 7'd54;
	localparam flowIdx_t flowDecL = 7'd56;

	// ALU flows are three words
	localparam flowIdx_t flowAddB = 7'd58;
	localparam flowIdx_t flowAddC = 7'd61;
	localparam flowIdx_t flowAddD = 7'd64;
	localparam flowIdx_t flowAddE = 7'd67;
	localparam flowIdx_t flowSubB = 7'd70;
	localparam flowIdx_t flowSubC = 7'd73;
	localparam flowIdx_t flowSubD = 7'd76;

	// Stack flows are six words, BC DE HL AF
	localparam flowIdx_t flowPushBc = 7'd79;
	localparam flowIdx_t flowPushDe = 7'd85;
	localparam flowIdx_t flowPushHl = 7'd91;
	localparam flowIdx_t flowPushAf = 7'd97;
	localparam flowIdx_t flowPopBc = 7'd103;
	localparam flowIdx_t flowPopDe = 7'd109;
	localparam flowIdx_t flowPopHl = 7'd115;
	localparam flowIdx_t flowPopAf = 7'd121;

endpackage

`default_nettype wire

//--- verilog/opcodeQueue.sv
`timescale 1ns/1ns
`default_nettype none
`include "ucode_settings.svh"

module opcodeQueue
(
	input wire clock,
	input wire rst,
	input wire wbCyc,
	input wire wbStb,
	input wire isaPkg::opcode_t wbDat,
	input wire opcodeTake,
	output logic wbAck,
	output logic opcodeValid,
	output isaPkg::opcode_t opcode
);

	localparam int depth = `UCODE_QUEUE_DEPTH;
	localparam int ptrW = $clog2(depth);

	isaPkg::opcode_t mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [ptrW:0] count;
	logic accept;
	logic pop;

	// No second write while the previous ack is still out
	assign accept = wbCyc && wbStb && !wbAck && (count != depth[ptrW:0]);
	assign pop = opcodeValid && opcodeTake;

	assign opcodeValid = (count != '0);
	assign opcode = mem[rdPtr];

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			mem[wrPtr] <= wbDat;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			wbAck <= 1'b0;
		end
		else
		begin
			wbAck <= accept;
			if (accept)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (accept && !pop)
				count <= count + 1'b1;
			else if (pop && !accept)
				count <= count - 1'b1;
		end
	end

	// Ack only answers a strobe
	assert property (@(posedge clock) disable iff (rst) wbAck |-> $past(wbStb));

endmodule

`default_nettype wire

//--- verilog/flowDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module flowDecoder
(
	input wire isaPkg::opcode_t opcode,
	input wire cbPrefixed,
	output ucodePkg::flowIdx_t flowIdx
);

	always_comb
	begin
		if (cbPrefixed)
		begin
			// Second byte after 0xCB
			case (opcode)
				isaPkg::opCbBit7H: flowIdx = ucodePkg::flowCbBit7H;
				isaPkg::opCbRlC: flowIdx = ucodePkg::flowCbRlC;
				default: flowIdx = ucodePkg::flowCbDefault;
			endcase
		end
		else
		begin
			case (opcode)
				isaPkg::opNop: flowIdx = ucodePkg::flowNop;
				isaPkg::opCbPrefix: flowIdx = ucodePkg::flowCbPrefix;
				isaPkg::opLdA: flowIdx = ucodePkg::flowLdA;
				isaPkg::opLdB: flowIdx = ucodePkg::flowLdB;
				isaPkg::opLdC: flowIdx = ucodePkg::flowLdC;
				isaPkg::opLdD: flowIdx = ucodePkg::flowLdD;
				isaPkg::opLdE: flowIdx = ucodePkg::flowLdE;
				isaPkg::opLdH: flowIdx = ucodePkg::flowLdH;
				isaPkg::opLdL: flowIdx = ucodePkg::flowLdL;
				isaPkg::opIncA: flowIdx = ucodePkg::flowIncA;
				isaPkg::opIncB: flowIdx = ucodePkg::flowIncB;
				isaPkg::opIncC: flowIdx = ucodePkg::flowIncC;
				isaPkg::opIncD: flowIdx = ucodePkg::flowIncD;
				isaPkg::opIncE: flowIdx = ucodePkg::flowIncE;
				isaPkg::opIncH: flowIdx = ucodePkg::flowIncH;
				isaPkg::opIncL: flowIdx = ucodePkg::flowIncL;
				isaPkg::opDecA: flowIdx = ucodePkg::flowDecA;
				isaPkg::opDecB: flowIdx = ucodePkg::flowDecB;
				isaPkg::opDecC: flowIdx = ucodePkg::flowDecC;
				isaPkg::opDecD: flowIdx = ucodePkg::flowDecD;
				isaPkg::opDecE: flowIdx = ucodePkg::flowDecE;
				isaPkg::opDecH: flowIdx = ucodePkg::flowDecH;
				isaPkg::opDecL: flowIdx = ucodePkg::flowDecL;
				isaPkg::opAddB: flowIdx = ucodePkg::flowAddB;
				isaPkg::opAddC: flowIdx = ucodePkg::flowAddC;
				isaPkg::opAddD: flowIdx = ucodePkg::flowAddD;
				isaPkg::opAddE: flowIdx = ucodePkg::flowAddE;
				isaPkg::opSubB: flowIdx = ucodePkg::flowSubB;
				isaPkg::opSubC: flowIdx = ucodePkg::flowSubC;
				isaPkg::opSubD: flowIdx = ucodePkg::flowSubD;
				isaPkg::opPushBc: flowIdx = ucodePkg::flowPushBc;
				isaPkg::opPushDe: flowIdx = ucodePkg::flowPushDe;
				isaPkg::opPushHl: flowIdx = ucodePkg::flowPushHl;
				isaPkg::opPushAf: flowIdx = ucodePkg::flowPushAf;
				isaPkg::opPopBc: flowIdx = ucodePkg::flowPopBc;
				isaPkg::opPopDe: flowIdx = ucodePkg::flowPopDe;
				isaPkg::opPopHl: flowIdx = ucodePkg::flowPopHl;
				isaPkg::opPopAf: flowIdx = ucodePkg::flowPopAf;
				default: flowIdx = ucodePkg::flowDefault;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/ucodeRom.sv
`timescale 1ns/1ns
`default_nettype none

module ucodeRom
(
	input wire ucodePkg::flowIdx_t addr,
	output ucodePkg::uop_t uop
);

	// Register order of the LD, INC and DEC groups
	localparam ucodePkg::uopOperand_e byteRegs [7] = '{ucodePkg::opdA, ucodePkg::opdB,
		ucodePkg::opdC, ucodePkg::opdD, ucodePkg::opdE, ucodePkg::opdH, ucodePkg::opdL};
	localparam ucodePkg::uopOperand_e pairHi [4] = '{ucodePkg::opdB, ucodePkg::opdD,
		ucodePkg::opdH, ucodePkg::opdA};
	localparam ucodePkg::uopOperand_e pairLo [4] = '{ucodePkg::opdC, ucodePkg::opdE,
		ucodePkg::opdL, ucodePkg::opdF};

	function automatic ucodePkg::uop_t mk(input logic inc, input logic eof, input logic fu,
		input ucodePkg::uopOp_e op, input ucodePkg::uopOperand_e opd);
		ucodePkg::uop_t u;
		u.incPc = inc;
		u.flowEnd = eof;
		u.updateFlags = fu;
		u.op = op;
		u.operand = opd;
		return u;
	endfunction

	always_comb
	begin
		int off;
		int ldOff;
		int incOff;
		int decOff;
		int aluOff;
		int pushOff;
		int popOff;
		off = int'(addr);
		ldOff = off - int'(ucodePkg::flowLdA);
		incOff = off - int'(ucodePkg::flowIncA);
		decOff = off - int'(ucodePkg::flowDecA);
		aluOff = off - int'(ucodePkg::flowAddB);
		pushOff = off - int'(ucodePkg::flowPushBc);
		popOff = off - int'(ucodePkg::flowPopBc);
		// Unused addresses end the flow doing nothing
		uop = mk(1'b0, 1'b1, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);

		//////////////////////////////
		// Single flows
		case (addr)
			ucodePkg::flowDefault: uop = mk(1'b0, 1'b0, 1'b1, ucodePkg::opZ801bop, ucodePkg::opdA);
			7'd1: uop = mk(1'b1, 1'b1, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);
			ucodePkg::flowNop: uop = mk(1'b1, 1'b1, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);
			ucodePkg::flowCbPrefix: uop = mk(1'b1, 1'b0, 1'b0, ucodePkg::opSma, ucodePkg::opdPc);
			7'd4: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);
			7'd5: uop = mk(1'b1, 1'b0, 1'b0, ucodePkg::opJcb, ucodePkg::opdNull);
			ucodePkg::flowCbBit7H: uop = mk(1'b0, 1'b1, 1'b1, ucodePkg::opBit, ucodePkg::opdH);
			ucodePkg::flowCbRlC: uop = mk(1'b0, 1'b1, 1'b1, ucodePkg::opShl, ucodePkg::opdC);
			default: ;
		endcase

		//////////////////////////////
		// Grouped flows, one body per register
		if (ldOff >= 0 && ldOff < 21)
		begin
			case (ldOff % 3)
				0: uop = mk(1'b1, 1'b0, 1'b0, ucodePkg::opSma, ucodePkg::opdPc);
				1: uop = mk(1'b1, 1'b0, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);
				default: uop = mk(1'b0, 1'b1, 1'b0, ucodePkg::opSrm, byteRegs[ldOff / 3]);
			endcase
		end
		else if (incOff >= 0 && incOff < 14)
		begin
			if (incOff % 2 == 0)
				uop = mk(1'b0, 1'b0, 1'b1, ucodePkg::opInc, byteRegs[incOff / 2]);
			else
				uop = mk(1'b1, 1'b1, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);
		end
		else if (decOff >= 0 && decOff < 14)
		begin
			if (decOff % 2 == 0)
				uop = mk(1'b0, 1'b0, 1'b1, ucodePkg::opDec, byteRegs[decOff / 2]);
			else
				uop = mk(1'b1, 1'b1, 1'b0, ucodePkg::opNop, ucodePkg::opdNull);
		end
		else if (aluOff >= 0 && aluOff < 21)
		begin
			// ADD A,B..E then SUB B..D, all through x16
			case (aluOff % 3)
				0: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSx16r, ucodePkg::opdA);
				1: uop = mk(1'b0, 1'b0, 1'b1, (aluOff < 12) ? ucodePkg::opAdd : ucodePkg::opSub,
					byteRegs[(aluOff < 12) ? aluOff / 3 + 1 : (aluOff - 12) / 3 + 1]);
				default: uop = mk(1'b1, 1'b1, 1'b0, ucodePkg::opSrx16, ucodePkg::opdA);
			endcase
		end
		else if (pushOff >= 0 && pushOff < 24)
		begin
			case (pushOff % 6)
				0, 3: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opDec, ucodePkg::opdSp);
				1: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSma, ucodePkg::opdSp);
				2: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSmw, pairHi[pushOff / 6]);
				4: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSmw, pairLo[pushOff / 6]);
				default: uop = mk(1'b1, 1'b1, 1'b0, ucodePkg::opSma, ucodePkg::opdPc);
			endcase
		end
		else if (popOff >= 0 && popOff < 24)
		begin
			case (popOff % 6)
				0: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSma, ucodePkg::opdSp);
				1: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opInc, ucodePkg::opdSp);
				2: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSrm, pairLo[popOff / 6]);
				3: uop = mk(1'b0, 1'b0, 1'b0, ucodePkg::opSrm, pairHi[popOff / 6]);
				4: uop = mk(1'b1, 1'b0, 1'b0, ucodePkg::opInc, ucodePkg::opdSp);
				default: uop = mk(1'b0, 1'b1, 1'b0, ucodePkg::opSma, ucodePkg::opdPc);
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/ucodeSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module ucodeSequencer
(
	input wire clock,
	input wire rst,
	input wire opcodeValid,
	input wire ucodePkg::flowIdx_t flowIdx,
	input wire ucodePkg::uop_t romUop,
	input wire uopReady,
	output logic opcodeTake,
	output logic cbPrefixed,
	output ucodePkg::flowIdx_t romAddr,
	output logic uopValid,
	output logic uopIncPc,
	output logic uopFlowEnd,
	output logic uopUpdateFlags,
	output ucodePkg::uopOp_e uopOp,
	output ucodePkg::uopOperand_e uopOperand
);

	typedef enum logic [1:0] {
		stIdle,
		stStream,
		stWaitCb
	} seqState_e;

	seqState_e state;
	ucodePkg::flowIdx_t curAddr;
	ucodePkg::uop_t outUop;
	logic transfer;

	assign transfer = uopValid && uopReady;

	// Outside a flow the decoder picks the address, inside it we step
	assign cbPrefixed = (state == stWaitCb);
	assign opcodeTake = (state != stStream) && opcodeValid;
	assign romAddr = (state == stStream) ? ucodePkg::flowIdx_t'(curAddr + 1'b1) : flowIdx;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= stIdle;
			uopValid <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle, stWaitCb:
				begin
					if (opcodeTake)
					begin
						state <= stStream;
						uopValid <= 1'b1;
					end
				end
				default:
				begin
					if (transfer && outUop.flowEnd)
					begin
						state <= stIdle;
						uopValid <= 1'b0;
					end
					else if (transfer && outUop.op == ucodePkg::opJcb)
					begin
						// Second byte of the CB pair comes from the queue
						state <= stWaitCb;
						uopValid <= 1'b0;
					end
				end
			endcase
		end
	end

	// Payload only moves on a load or a transfer
	always_ff @(posedge clock)
	begin
		if (opcodeTake || (state == stStream && transfer))
		begin
			outUop <= romUop;
			curAddr <= romAddr;
		end
	end

	assign uopIncPc = outUop.incPc;
	assign uopFlowEnd = outUop.flowEnd;
	assign uopUpdateFlags = outUop.updateFlags;
	assign uopOp = outUop.op;
	assign uopOperand = outUop.operand;

	// Stalled micro-op holds until the consumer takes it
	assert property (@(posedge clock) disable iff (rst)
		uopValid && !uopReady |=> uopValid && $stable(outUop));

endmodule

`default_nettype wire

//--- verilog/microcodeUnit.sv
`timescale 1ns/1ns
`default_nettype none

module microcodeUnit
(
	input wire clock,
	input wire rst,
	input wire wbCyc,
	input wire wbStb,
	input wire isaPkg::opcode_t wbDat,
	input wire uopReady,
	output logic wbAck,
	output logic uopValid,
	output logic uopIncPc,
	output logic uopFlowEnd,
	output logic uopUpdateFlags,
	output ucodePkg::uopOp_e uopOp,
	output ucodePkg::uopOperand_e uopOperand
);

	logic opcodeValid;
	logic opcodeTake;
	logic cbPrefixed;
	isaPkg::opcode_t opcode;
	ucodePkg::flowIdx_t flowIdx;
	ucodePkg::flowIdx_t romAddr;
	ucodePkg::uop_t romUop;

	opcodeQueue u_queue (.clock(clock), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb),
		.wbDat(wbDat), .opcodeTake(opcodeTake), .wbAck(wbAck),
		.opcodeValid(opcodeValid), .opcode(opcode));

	flowDecoder u_decoder (.opcode(opcode), .cbPrefixed(cbPrefixed), .flowIdx(flowIdx));

	ucodeRom u_rom (.addr(romAddr), .uop(romUop));

	ucodeSequencer u_seq (.clock(clock), .rst(rst), .opcodeValid(opcodeValid),
		.flowIdx(flowIdx), .romUop(romUop), .uopReady(uopReady),
		.opcodeTake(opcodeTake), .cbPrefixed(cbPrefixed), .romAddr(romAddr),
		.uopValid(uopValid), .uopIncPc(uopIncPc), .uopFlowEnd(uopFlowEnd),
		.uopUpdateFlags(uopUpdateFlags), .uopOp(uopOp), .uopOperand(uopOperand));

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock
(
	output logic clock,
	output logic rst
);

	// 10 ns period
	initial
	begin
		clock = 1'b0;
		forever
			#5 clock = ~clock;
	end

	// High for two rising edges, released on a falling edge
	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/microcodeUnitTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "ucode_settings.svh"

module microcodeUnitTb;

	localparam int idleLimit = 200;
	localparam int keptCount = 37;
	localparam int patternLen = 256;

	// Kept one-byte opcodes, grouped by flow shape
	// 0 NOP, 1..7 LD r,n, 8..21 INC/DEC, 22..28 ADD/SUB, 29..36 PUSH/POP
	localparam isaPkg::opcode_t keptOps [keptCount] = '{
		isaPkg::opNop,
		isaPkg::opLdA, isaPkg::opLdB, isaPkg::opLdC, isaPkg::opLdD,
		isaPkg::opLdE, isaPkg::opLdH, isaPkg::opLdL,
		isaPkg::opIncA, isaPkg::opIncB, isaPkg::opIncC, isaPkg::opIncD,
		isaPkg::opIncE, isaPkg::opIncH, isaPkg::opIncL,
		isaPkg::opDecA, isaPkg::opDecB, isaPkg::opDecC, isaPkg::opDecD,
		isaPkg::opDecE, isaPkg::opDecH, isaPkg::opDecL,
		isaPkg::opAddB, isaPkg::opAddC, isaPkg::opAddD, isaPkg::opAddE,
		isaPkg::opSubB, isaPkg::opSubC, isaPkg::opSubD,
		isaPkg::opPushBc, isaPkg::opPushDe, isaPkg::opPushHl, isaPkg::opPushAf,
		isaPkg::opPopBc, isaPkg::opPopDe, isaPkg::opPopHl, isaPkg::opPopAf};

	logic clock;
	logic rst;
	logic wbCyc;
	logic wbStb;
	isaPkg::opcode_t wbDat;
	logic uopReady;
	logic wbAck;
	logic uopValid;
	logic uopIncPc;
	logic uopFlowEnd;
	logic uopUpdateFlags;
	ucodePkg::uopOp_e uopOp;
	ucodePkg::uopOperand_e uopOperand;

	logic [15:0] lfsr = 16'd43403;
	bit readyPattern [patternLen];
	int readyIdx = 0;
	int checks = 0;
	int errors = 0;

	// Bytes to write and the expected flows, in order
	isaPkg::opcode_t stim [$];
	int expUops [$];
	int expPc [$];
	int expFlags [$];

	tbClock u_clock (.clock(clock), .rst(rst));

	microcodeUnit u_dut (.clock(clock), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb),
		.wbDat(wbDat), .uopReady(uopReady), .wbAck(wbAck), .uopValid(uopValid),
		.uopIncPc(uopIncPc), .uopFlowEnd(uopFlowEnd), .uopUpdateFlags(uopUpdateFlags),
		.uopOp(uopOp), .uopOperand(uopOperand));

	//////////////////////////////
	// Random numbers

	function automatic bit stepLfsr();
		bit outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 16'hB400;
		return outBit;
	endfunction

	function automatic int randBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++)
			value = (value << 1) | int'(stepLfsr());
		return value;
	endfunction

	//////////////////////////////
	// Flow model

	function automatic int keptIndex(input isaPkg::opcode_t b);
		for (int i = 0; i < keptCount; i++)
			if (keptOps[i] == b)
				return i;
		return -1;
	endfunction

	function automatic void expectCounts(input int uops, input int pcs, input int flags);
		expUops.push_back(uops);
		expPc.push_back(pcs);
		expFlags.push_back(flags);
	endfunction

	function automatic void pushExpected(input isaPkg::opcode_t first,
		input isaPkg::opcode_t second);
		int idx;
		idx = keptIndex(first);
		if (first == isaPkg::opCbPrefix)
		begin
			if (second == isaPkg::opCbBit7H || second == isaPkg::opCbRlC)
				expectCounts(4, 2, 1);
			else
				expectCounts(4, 2, 0);
		end
		else if (idx == 0)
			expectCounts(1, 1, 0);
		else if (idx >= 1 && idx <= 7)
			expectCounts(3, 2, 0);
		else if (idx >= 8 && idx <= 21)
			expectCounts(2, 1, 1);
		else if (idx >= 22 && idx <= 28)
			expectCounts(3, 1, 1);
		else if (idx >= 29)
			expectCounts(6, 1, 0);
		else
			expectCounts(2, 1, 1);
	endfunction

	// Kind 0 kept opcode, 1 CB pair, 2 unknown byte
	function automatic void addInstr(input int kind);
		isaPkg::opcode_t first;
		isaPkg::opcode_t second;
		second = 8'h00;
		if (kind == 1)
		begin
			first = isaPkg::opCbPrefix;
			if (randBits(1) != 0)
				second = (randBits(1) != 0) ? isaPkg::opCbBit7H : isaPkg::opCbRlC;
			else
				second = isaPkg::opcode_t'(randBits(8));
			stim.push_back(first);
			stim.push_back(second);
		end
		else if (kind == 2)
		begin
			first = isaPkg::opcode_t'(randBits(8));
			while (keptIndex(first) >= 0 || first == isaPkg::opCbPrefix)
				first = first + 1'b1;
			stim.push_back(first);
		end
		else
		begin
			first = keptOps[randBits(6) % keptCount];
			stim.push_back(first);
		end
		pushExpected(first, second);
	endfunction

	//////////////////////////////
	// Checks and bus tasks

	task automatic checkValue(input string name, input int actual, input int expected);
		checks++;
		if (actual != expected)
		begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			errors++;
		end
	endtask

	function automatic int uopFields();
		return int'({uopIncPc, uopFlowEnd, uopUpdateFlags, uopOp, uopOperand});
	endfunction

	task automatic startWrite(input isaPkg::opcode_t b);
		@(negedge clock);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbDat = b;
	endtask

	// Quiet mode also expects no micro-op up to and with the ack
	task automatic finishWrite(input bit quiet);
		int waitCount;
		waitCount = 0;
		forever
		begin
			@(negedge clock);
			if (quiet)
				checkValue("uopValid", uopValid, 0);
			if (wbAck)
				break;
			waitCount++;
			if (waitCount > idleLimit)
			begin
				$display("Timeout at %0t: write of %h never acknowledged", $time, wbDat);
				errors++;
				break;
			end
		end
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	task automatic writeOpcode(input isaPkg::opcode_t b, input bit quiet);
		startWrite(b);
		finishWrite(quiet);
	endtask

	task automatic writeAll();
		foreach (stim[i])
			writeOpcode(stim[i], 1'b0);
		stim.delete();
	endtask

	task automatic consumeFlows(input bit useGaps);
		int idle;
		int uops;
		int pcs;
		int flags;
		int held;
		bit stalled;
		bit ready;
		idle = 0;
		uops = 0;
		pcs = 0;
		flags = 0;
		held = 0;
		stalled = 1'b0;
		while (expUops.size() > 0)
		begin
			@(negedge clock);
			// A stalled micro-op must still be there, unchanged
			if (stalled)
			begin
				checkValue("uopValid", uopValid, 1);
				checkValue("uop fields", uopFields(), held);
			end
			ready = useGaps ? readyPattern[readyIdx % patternLen] : 1'b1;
			readyIdx++;
			uopReady = ready;
			stalled = uopValid && !ready;
			held = uopFields();
			idle++;
			if (uopValid && ready)
			begin
				uops++;
				pcs += int'(uopIncPc);
				flags += int'(uopUpdateFlags);
				if (uopFlowEnd)
				begin
					checkValue("micro-op count", uops, expUops.pop_front());
					checkValue("pc increments", pcs, expPc.pop_front());
					checkValue("flag updates", flags, expFlags.pop_front());
					uops = 0;
					pcs = 0;
					flags = 0;
					idle = 0;
				end
			end
			// Counts cycles since the last flow end
			if (idle > idleLimit)
			begin
				$display("Timeout at %0t: no flow ended with %0d flows left",
					$time, expUops.size());
				errors++;
				expUops.delete();
				expPc.delete();
				expFlags.delete();
			end
		end
	endtask

	task automatic runBatch(input bit useGaps);
		fork
			writeAll();
			consumeFlows(useGaps);
		join
	endtask

	task automatic reportTest(input int num, input string title, input int errStart);
		$display("Test %0d %s: %s", num, title, (errors == errStart) ? "ok" : "failed");
	endtask

	//////////////////////////////
	// Test sequence

	initial
	begin
		int errStart;
		int waitCount;
		int k;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbDat = 8'h00;
		uopReady = 1'b0;
		for (int i = 0; i < patternLen; i++)
			readyPattern[i] = (randBits(2) != 0);

		waitCount = 0;
		do
		begin
			@(posedge clock);
			waitCount++;
		end
		while (rst !== 1'b0 && waitCount < 20);
		if (rst !== 1'b0)
		begin
			$display("Reset was never released");
			errors++;
		end
		@(negedge clock);

		// Quiet after reset, then one NOP
		errStart = errors;
		checkValue("uopValid", uopValid, 0);
		checkValue("wbAck", wbAck, 0);
		uopReady = 1'b1;
		repeat (20)
		begin
			@(negedge clock);
			checkValue("uopValid", uopValid, 0);
		end
		pushExpected(isaPkg::opNop, 8'h00);
		writeOpcode(isaPkg::opNop, 1'b1);
		consumeFlows(1'b0);
		reportTest(1, "reset state", errStart);

		errStart = errors;
		for (int i = 0; i < 40; i++)
			addInstr(0);
		runBatch(1'b0);
		reportTest(2, "kept opcodes", errStart);

		errStart = errors;
		for (int i = 0; i < 20; i++)
			addInstr(1);
		runBatch(1'b0);
		reportTest(3, "CB pairs", errStart);

		errStart = errors;
		for (int i = 0; i < 20; i++)
			addInstr(2);
		runBatch(1'b0);
		reportTest(4, "unknown opcodes", errStart);

		errStart = errors;
		for (int i = 0; i < 60; i++)
		begin
			k = randBits(2);
			addInstr((k == 3) ? 0 : k);
		end
		runBatch(1'b1);
		reportTest(5, "ready gaps", errStart);

		// Consumer stalled while the FIFO fills
		errStart = errors;
		@(negedge clock);
		uopReady = 1'b0;
		for (int i = 0; i < `UCODE_QUEUE_DEPTH + 2; i++)
			addInstr(0);
		for (int i = 0; i <= `UCODE_QUEUE_DEPTH; i++)
			writeOpcode(stim[i], 1'b0);
		// One byte in the sequencer and a full FIFO, so this write waits
		startWrite(stim[`UCODE_QUEUE_DEPTH + 1]);
		repeat (16)
		begin
			@(negedge clock);
			checkValue("wbAck", wbAck, 0);
		end
		stim.delete();
		fork
			finishWrite(1'b0);
			consumeFlows(1'b0);
		join
		reportTest(6, "full queue", errStart);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ucodePkg.sv
verilog/opcodeQueue.sv
verilog/flowDecoder.sv
verilog/ucodeRom.sv
verilog/ucodeSequencer.sv
verilog/microcodeUnit.sv
tests/tbClock.sv
tests/microcodeUnitTb.sv
